//--- filelist.f
boot_pkg.sv
uart_rx.sv
prog_loader.sv
code_ram.sv
prog_ram_top.sv
prog_ram_properties.sv
tb_prog_ram.sv

//--- tb_prog_ram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_prog_ram;
  import boot_pkg::*;

  localparam int BIT_CLKS   = 16;
  localparam int FRAMES     = 66;
  // All serial frames, the key gap, bus traffic and some margin
  localparam int RUN_CYCLES = FRAMES * 10 * BIT_CLKS + GAP_CYCLES + 3000;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              ser_rx_i;
  logic [ADDR_W-1:0] bus_addr_wr_i;
  logic [DATA_W-1:0] bus_wdata_i;
  logic [NB_COL-1:0] bus_strb_i;
  logic              bus_rd_en_i;
  logic [ADDR_W-1:0] bus_addr_rd_i;
  logic [DATA_W-1:0] bus_rdata_o;
  logic              prog_mode_o;
  logic              sys_rst_no;

  logic [DATA_W-1:0] model [RAM_DEPTH];
  logic [DATA_W-1:0] rd_expect;
  logic [DATA_W-1:0] exp_q;
  logic [31:0]       rng = 32'h3d24;
  int                errors = 0;
  int                checks = 0;
  int                rst_pulses = 0;
  int                mode_cycles = 0;
  int                pulses_before;
  int                mode_before;

  always #10 clk_i = ~clk_i;

  prog_ram_top prog_ram_top_i (.*);

  // Count reset pulses and programming cycles
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!sys_rst_no) rst_pulses <= rst_pulses + 1;
      if (prog_mode_o) mode_cycles <= mode_cycles + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read data check
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (bus_rd_en_i) begin
      exp_q <= rd_expect;
    end
  end

  read_data_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_rd_en_i |=> bus_rdata_o == exp_q)
  else begin
    errors++;
    $display("Error at %0t: bus_rdata_o expected %h got %h", $time,
             $sampled(exp_q), $sampled(bus_rdata_o));
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 8N1 frame, LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      ser_rx_i = frame[i];
      repeat (BIT_CLKS - 1) @(negedge clk_i);
    end
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 3; i >= 0; i--) begin
      send_byte(w[i*8 +: 8]);
    end
  endtask

  // Key, word count, then n random words
  task automatic send_load(input logic [31:0] key, input int n, input bit commit);
    logic [31:0] w;
    send_word(key);
    send_word(32'(n));
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      w   = rng;
      send_word(w);
      if (commit) model[i] = w;
    end
  endtask

  task automatic bus_write(input int addr, input logic [31:0] data, input logic [3:0] strb);
    @(negedge clk_i);
    bus_addr_wr_i = addr[ADDR_W-1:0];
    bus_wdata_i   = data;
    bus_strb_i    = strb;
    for (int c = 0; c < NB_COL; c++) begin
      if (strb[c]) model[addr][c*8 +: 8] = data[c*8 +: 8];
    end
    @(negedge clk_i);
    bus_strb_i = '0;
  endtask

  task automatic read_range(input int n);
    for (int a = 0; a < n; a++) begin
      @(negedge clk_i);
      bus_rd_en_i   = 1'b1;
      bus_addr_rd_i = a[ADDR_W-1:0];
      rd_expect     = model[a];
      checks++;
      @(negedge clk_i);
      bus_rd_en_i = 1'b0;
    end
  endtask

  // Four-state compare so an unknown output counts as wrong
  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Check failed at %0t: %s", $time, what);
    end
  endtask

  task automatic wait_reset_pulse();
    int n;
    n = 0;
    while (rst_pulses == pulses_before && n < 400) begin
      @(negedge clk_i);
      n++;
    end
    if (rst_pulses == pulses_before) begin
      errors++;
      $display("Timeout: sys_rst_no never pulsed after the load");
    end
    repeat (5) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    ser_rx_i      = 1'b1;
    bus_addr_wr_i = '0;
    bus_wdata_i   = '0;
    bus_strb_i    = '0;
    bus_rd_en_i   = 1'b0;
    bus_addr_rd_i = '0;
    rd_expect     = '0;
    for (int i = 0; i < RAM_DEPTH; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    expect_equal("prog_mode_o", 0, prog_mode_o);
    expect_equal("sys_rst_no", 1, sys_rst_no);
    expect_equal("bus_rdata_o", 0, bus_rdata_o);
    read_range(1);

    // Full words, then partial strobes on top
    for (int a = 0; a < 10; a++) begin
      rng = xorshift32(rng);
      bus_write(a, rng, 4'hf);
      rng = xorshift32(rng);
      bus_write(a, rng, 4'(a % 15 + 1));
    end
    read_range(10);

    pulses_before = rst_pulses;
    mode_before   = mode_cycles;
    send_load("LOAD", 6, 1'b1);
    wait_reset_pulse();
    expect_equal("sys_rst_no pulses", pulses_before + 1, rst_pulses);
    expect_true(mode_cycles > mode_before, "prog_mode_o never rose during the load");
    expect_equal("prog_mode_o", 0, prog_mode_o);
    read_range(10);

    // Wrong key, nothing may change
    pulses_before = rst_pulses;
    mode_before   = mode_cycles;
    send_load("LOAX", 2, 1'b0);
    repeat (40) @(negedge clk_i);
    expect_equal("sys_rst_no pulses", pulses_before, rst_pulses);
    expect_equal("prog_mode_o cycles", mode_before, mode_cycles);
    read_range(10);

    // Partial key dropped after a long gap
    pulses_before = rst_pulses;
    mode_before   = mode_cycles;
    send_byte("L");
    send_byte("O");
    repeat (GAP_CYCLES + 200) @(negedge clk_i);
    send_load("LOAD", 2, 1'b1);
    wait_reset_pulse();
    expect_equal("sys_rst_no pulses", pulses_before + 1, rst_pulses);
    expect_true(mode_cycles > mode_before, "prog_mode_o never rose during the load");
    read_range(10);

    repeat (3) @(negedge clk_i);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * 20);
    $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- prog_ram_properties.sv
`timescale 1ns/10ps
`default_nettype none

module prog_ram_properties (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        bus_rd_en_i,
  input logic [boot_pkg::DATA_W-1:0] bus_rdata_o,
  input logic                        prog_mode_o,
  input logic                        sys_rst_no
);

  //////////////////////////////////////////////////////////////////////
  // Loader reset pulse
  //////////////////////////////////////////////////////////////////////

  // Pulse lasts a single cycle
  rst_pulse_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sys_rst_no |=> sys_rst_no)
  else $error("sys_rst_no low for more than one cycle");

  // End of programming releases the system reset
  mode_end_resets: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(prog_mode_o) |-> ##[1:2] !sys_rst_no)
  else $error("prog_mode_o fell without a sys_rst_no pulse");

  mode_rst_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(prog_mode_o && !sys_rst_no))
  else $error("prog_mode_o high while sys_rst_no is low");

  // Read data register only moves on a read
  rdata_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !bus_rd_en_i |=> $stable(bus_rdata_o))
  else $error("bus_rdata_o changed without a read");

endmodule

bind prog_ram_top prog_ram_properties prog_ram_properties_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .bus_rd_en_i (bus_rd_en_i),
  .bus_rdata_o (bus_rdata_o),
  .prog_mode_o (prog_mode_o),
  .sys_rst_no  (sys_rst_no)
);

`default_nettype wire

//--- prog_ram_top.sv
`timescale 1ns/10ps
`default_nettype none

module prog_ram_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        ser_rx_i,
  input  logic [boot_pkg::ADDR_W-1:0] bus_addr_wr_i,
  input  logic [boot_pkg::DATA_W-1:0] bus_wdata_i,
  input  logic [boot_pkg::NB_COL-1:0] bus_strb_i,
  input  logic                        bus_rd_en_i,
  input  logic [boot_pkg::ADDR_W-1:0] bus_addr_rd_i,
  output logic [boot_pkg::DATA_W-1:0] bus_rdata_o,
  output logic                        prog_mode_o,
  output logic                        sys_rst_no
);
  import boot_pkg::*;

  logic [COL_W-1:0]  rx_byte;
  logic              rx_valid;
  logic              prog_we;
  logic [ADDR_W-1:0] prog_addr;
  logic [DATA_W-1:0] prog_data;

  // Serial byte recovery
  uart_rx uart_rx_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ser_rx_i   (ser_rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  prog_loader prog_loader_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_byte_i   (rx_byte),
    .rx_valid_i  (rx_valid),
    .prog_we_o   (prog_we),
    .prog_addr_o (prog_addr),
    .prog_data_o (prog_data),
    .prog_mode_o (prog_mode_o),
    .sys_rst_no  (sys_rst_no)
  );

  code_ram code_ram_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .bus_addr_wr_i (bus_addr_wr_i),
    .bus_wdata_i   (bus_wdata_i),
    .bus_strb_i    (bus_strb_i),
    .bus_rd_en_i   (bus_rd_en_i),
    .bus_addr_rd_i (bus_addr_rd_i),
    .bus_rdata_o   (bus_rdata_o),
    .prog_we_i     (prog_we),
    .prog_addr_i   (prog_addr),
    .prog_data_i   (prog_data)
  );

endmodule

`default_nettype wire

//--- code_ram.sv
`timescale 1ns/10ps
`default_nettype none

module code_ram (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [boot_pkg::ADDR_W-1:0] bus_addr_wr_i,
  input  logic [boot_pkg::DATA_W-1:0] bus_wdata_i,
  input  logic [boot_pkg::NB_COL-1:0] bus_strb_i,
  input  logic                        bus_rd_en_i,
  input  logic [boot_pkg::ADDR_W-1:0] bus_addr_rd_i,
  output logic [boot_pkg::DATA_W-1:0] bus_rdata_o,
  input  logic                        prog_we_i,
  input  logic [boot_pkg::ADDR_W-1:0] prog_addr_i,
  input  logic [boot_pkg::DATA_W-1:0] prog_data_i
);
  import boot_pkg::*;

  logic [DATA_W-1:0] mem [RAM_DEPTH];
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [NB_COL-1:0] wr_col;

  // Loader owns the write port while it writes
  assign wr_addr = prog_we_i ? prog_addr_i : bus_addr_wr_i;
  assign wr_data = prog_we_i ? prog_data_i : bus_wdata_i;
  assign wr_col  = prog_we_i ? {NB_COL{1'b1}} : bus_strb_i;

  // Power-up contents are zero
  initial begin
    for (int i = 0; i < RAM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte-column write
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    for (int c = 0; c < NB_COL; c++) begin
      if (wr_col[c]) begin
        mem[wr_addr][c*COL_W +: COL_W] <= wr_data[c*COL_W +: COL_W];
      end
    end
  end

  // Registered read, holds between reads
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      bus_rdata_o <= '0;
    end else if (bus_rd_en_i) begin
      bus_rdata_o <= mem[bus_addr_rd_i];
    end
  end

endmodule

`default_nettype wire

//--- prog_loader.sv
`timescale 1ns/10ps
`default_nettype none

module prog_loader (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [boot_pkg::COL_W-1:0]  rx_byte_i,
  input  logic                        rx_valid_i,
  output logic                        prog_we_o,
  output logic [boot_pkg::ADDR_W-1:0] prog_addr_o,
  output logic [boot_pkg::DATA_W-1:0] prog_data_o,
  output logic                        prog_mode_o,
  output logic                        sys_rst_no
);
  import boot_pkg::*;

  loader_state_e                   state_q;
  loader_state_e                   state_d;
  logic [KEY_LEN*COL_W-1:0]        key_q;
  logic [$clog2(KEY_LEN)-1:0]      key_cnt_q;
  logic [$clog2(GAP_CYCLES+1)-1:0] idle_q;
  logic [$clog2(NB_COL)-1:0]       byte_cnt_q;
  logic [DATA_W-1:0]               count_q;
  logic [DATA_W-1:0]               word_q;
  logic [DATA_W-1:0]               written_q;
  logic                            last_key_byte;
  logic                            last_byte;
  logic                            gap_expired;

  assign last_key_byte = key_cnt_q == $bits(key_cnt_q)'(KEY_LEN - 1);
  assign last_byte     = byte_cnt_q == $bits(byte_cnt_q)'(NB_COL - 1);
  assign gap_expired   = idle_q == $bits(idle_q)'(GAP_CYCLES);

  assign prog_mode_o = state_q == PROGRAM;
  assign prog_data_o = word_q;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      KEY_WAIT: begin
        if (rx_valid_i) begin
          state_d = KEY_RECV;
        end
      end
      KEY_RECV: begin
        if (rx_valid_i) begin
          if (last_key_byte) begin
            state_d = KEY_CHECK;
          end
        end else if (gap_expired) begin
          // Too slow, drop the partial key
          state_d = KEY_WAIT;
        end
      end
      KEY_CHECK: begin
        state_d = (key_q == PROG_KEY) ? LEN_RECV : KEY_WAIT;
      end
      LEN_RECV: begin
        if (rx_valid_i && last_byte) begin
          state_d = PROGRAM;
        end
      end
      PROGRAM: begin
        // Also taken on the first cycle for an empty load
        if (written_q == count_q) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        state_d = KEY_WAIT;
      end
      default: state_d = KEY_WAIT;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Control registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q     <= KEY_WAIT;
      key_cnt_q   <= '0;
      idle_q      <= '0;
      byte_cnt_q  <= '0;
      written_q   <= '0;
      prog_addr_o <= '0;
      prog_we_o   <= 1'b0;
      sys_rst_no  <= 1'b1;
    end else begin
      state_q    <= state_d;
      prog_we_o  <= 1'b0;
      sys_rst_no <= 1'b1;
      // Advance after each word written
      if (prog_we_o) begin
        prog_addr_o <= prog_addr_o + 1'b1;
        written_q   <= written_q + 1'b1;
      end
      case (state_q)
        KEY_WAIT: begin
          idle_q <= '0;
          if (rx_valid_i) begin
            key_cnt_q <= $bits(key_cnt_q)'(1);
          end
        end
        KEY_RECV: begin
          if (rx_valid_i) begin
            idle_q    <= '0;
            key_cnt_q <= last_key_byte ? '0 : key_cnt_q + 1'b1;
          end else if (gap_expired) begin
            idle_q    <= '0;
            key_cnt_q <= '0;
          end else begin
            idle_q <= idle_q + 1'b1;
          end
        end
        KEY_CHECK: begin
          byte_cnt_q <= '0;
        end
        LEN_RECV: begin
          written_q <= '0;
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
        end
        PROGRAM: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_byte) begin
              prog_we_o <= 1'b1;
            end
          end
        end
        FINISH: begin
          sys_rst_no  <= 1'b0;
          prog_addr_o <= '0;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Byte assembly, most significant byte first
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      case (state_q)
        KEY_WAIT, KEY_RECV: key_q <= {key_q[(KEY_LEN-1)*COL_W-1:0], rx_byte_i};
        LEN_RECV:           count_q <= {count_q[DATA_W-COL_W-1:0], rx_byte_i};
        PROGRAM:            word_q <= {word_q[DATA_W-COL_W-1:0], rx_byte_i};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ser_rx_i,
  output logic [boot_pkg::COL_W-1:0] rx_byte_o,
  output logic                       rx_valid_o
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  rx_state_e                       state_q;
  logic [1:0]                      sync_q;
  logic [$clog2(CLKS_PER_BIT)-1:0] tick_q;
  logic [$clog2(COL_W)-1:0]        bit_q;
  logic [COL_W-1:0]                shift_q;
  logic                            rx_line;
  logic                            tick_half;
  logic                            tick_full;
  logic                            last_bit;

  assign rx_line   = sync_q[1];
  assign tick_half = tick_q == $bits(tick_q)'(CLKS_PER_BIT / 2 - 1);
  assign tick_full = tick_q == $bits(tick_q)'(CLKS_PER_BIT - 1);
  assign last_bit  = bit_q == $bits(bit_q)'(COL_W - 1);
  assign rx_byte_o = shift_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sync_q     <= 2'b11;
      state_q    <= RX_IDLE;
      tick_q     <= '0;
      bit_q      <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      // Line idles high, two flops against metastability
      sync_q     <= {sync_q[0], ser_rx_i};
      rx_valid_o <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          tick_q <= '0;
          bit_q  <= '0;
          if (!rx_line) begin
            state_q <= RX_START;
          end
        end
        RX_START: begin
          // Recheck in the middle of the start bit to reject glitches
          if (tick_half) begin
            tick_q  <= '0;
            state_q <= rx_line ? RX_IDLE : RX_DATA;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (tick_full) begin
            tick_q <= '0;
            bit_q  <= bit_q + 1'b1;
            if (last_bit) begin
              state_q <= RX_STOP;
            end
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        RX_STOP: begin
          if (tick_full) begin
            tick_q     <= '0;
            rx_valid_o <= rx_line;
            state_q    <= RX_IDLE;
          end else begin
            tick_q <= tick_q + 1'b1;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == RX_DATA && tick_full) begin
      shift_q <= {rx_line, shift_q[COL_W-1:1]};
    end
  end

endmodule

`default_nettype wire

//--- boot_pkg.sv
`default_nettype none

package boot_pkg;

  //////////////////////////////////////////////////////////////////////
  // Memory geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NB_COL    = 4;
  localparam int COL_W     = 8;
  localparam int DATA_W    = NB_COL * COL_W;
  localparam int RAM_DEPTH = 1024;
  localparam int ADDR_W    = 10;

  //////////////////////////////////////////////////////////////////////
  // Serial link and loader protocol
  //////////////////////////////////////////////////////////////////////

  localparam int CLKS_PER_BIT = 16;

  // Key is matched first character in the top byte
  localparam int                       KEY_LEN  = 4;
  localparam logic [KEY_LEN*COL_W-1:0] PROG_KEY = "LOAD";

  // Idle cycles allowed between two key characters
  localparam int GAP_CYCLES = 400;

  typedef enum logic [2:0] {
    KEY_WAIT,
    KEY_RECV,
    KEY_CHECK,
    LEN_RECV,
    PROGRAM,
    FINISH
  } loader_state_e;

endpackage

`default_nettype wire
